//--- src/forthBranch_config.svh
`ifndef FORTH_BRANCH_CONFIG_SVH
`define FORTH_BRANCH_CONFIG_SVH

// Datapath width
// Shared by the PC, the D operand and the ALU result
`define FORTH_DATA_WIDTH 16

// Address of the first instruction out of reset
`define FORTH_RESET_PC 16'h0100

// Sequential advance between instructions
`define FORTH_PC_STEP 1

`endif

//--- src/forthBranchPkg.sv
`default_nettype none

`include "forthBranch_config.svh"

package forthBranchPkg;

	// Top nibble of every instruction word
	typedef enum logic [3:0] {
		GROUP_NOP    = 4'h0,
		GROUP_ALU    = 4'h1,
		GROUP_LOAD   = 4'h2,
		GROUP_STORE  = 4'h3,
		GROUP_BRANCH = 4'hF
	} instrGroupT;

	// Condition code picked by a conditional branch
	typedef enum logic [1:0] {
		CC_Z = 2'd0,
		CC_S = 2'd1,
		CC_P = 2'd2,
		CC_C = 2'd3
	} ccSelectT;

	// Offset added to the base, 1 for a step
	typedef enum logic {
		PC_OFFSET_NONE = 1'b0,
		PC_OFFSET_D    = 1'b1
	} pcOffsetSelT;

	typedef enum logic [1:0] {
		PC_BASE_PC   = 2'd0,
		PC_BASE_ZERO = 2'd1,
		PC_BASE_PCA  = 2'd2
	} pcBaseSelT;

	typedef struct packed {
		instrGroupT group;
		logic       jr;
		logic       ccApply;
		logic       ccInvert;
		ccSelectT   ccSelect;
		logic [6:0] reserved;
	} branchViewT;

	typedef struct packed {
		instrGroupT  group;
		logic        writeFlags;
		logic [10:0] opcode;
	} aluViewT;

	// Same word, decoded per group
	typedef union packed {
		branchViewT branchView;
		aluViewT    aluView;
	} instrWordT;

	// Everything the execute stage needs for one instruction
	typedef struct packed {
		logic                         valid;
		logic                         jmp;
		logic                         jr;
		logic                         ccApply;
		logic                         ccInvert;
		ccSelectT                     ccSelect;
		logic                         writeFlags;
		logic [`FORTH_DATA_WIDTH-1:0] dValue;
		logic [`FORTH_DATA_WIDTH-1:0] aluResult;
		logic                         aluCarry;
		logic [`FORTH_DATA_WIDTH-1:0] pcA;
	} execOpT;

	typedef struct packed {
		logic z;
		logic s;
		logic p;
		logic c;
	} flagsT;

endpackage

`default_nettype wire

//--- src/instructionDecoder.sv
`default_nettype none

`include "forthBranch_config.svh"

module instructionDecoder import forthBranchPkg::*; (
	input  logic                         CLK,
	input  logic                         reset,
	input  logic                         instrValid,
	input  instrWordT                    instr,
	input  logic [`FORTH_DATA_WIDTH-1:0] dValue,
	input  logic [`FORTH_DATA_WIDTH-1:0] aluResult,
	input  logic                         aluCarry,
	input  logic [`FORTH_DATA_WIDTH-1:0] pc,
	output execOpT                       execOp
);

	execOpT decoded;
	execOpT opReg;
	logic   isBranch;

	assign isBranch = (instr.branchView.group == GROUP_BRANCH);

	always_comb begin
		decoded = '0;
		decoded.valid = instrValid;
		decoded.dValue = dValue;
		decoded.aluResult = aluResult;
		decoded.aluCarry = aluCarry;
		decoded.pcA = pc;
		if (isBranch) begin
			// Branch words never touch the flags
			decoded.jmp = 1'b1;
			decoded.jr = instr.branchView.jr;
			decoded.ccApply = instr.branchView.ccApply;
			decoded.ccInvert = instr.branchView.ccInvert;
			decoded.ccSelect = instr.branchView.ccSelect;
		end else begin
			decoded.writeFlags = instr.aluView.writeFlags;
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			opReg.valid <= 1'b0;
			opReg.jmp <= 1'b0;
			opReg.writeFlags <= 1'b0;
		end else if (instrValid) begin
			opReg <= decoded;
		end else begin
			opReg.valid <= 1'b0;
			opReg.jmp <= 1'b0;
			opReg.writeFlags <= 1'b0;
		end
	end

	// Own address is the live PC.
	// The previous instruction has already retired into it, so a
	// branch right behind another branch sees the new target.
	always_comb begin
		execOp = opReg;
		execOp.pcA = pc;
	end

endmodule

`default_nettype wire

//--- src/conditionCodes.sv
`default_nettype none

`include "forthBranch_config.svh"

module conditionCodes import forthBranchPkg::*; (
	input  logic   CLK,
	input  logic   reset,
	input  execOpT execOp,
	output flagsT  flags
);

	flagsT nextFlags;
	logic  flagWrite;

	assign flagWrite = execOp.valid && execOp.writeFlags;

	always_comb begin
		nextFlags.z = (execOp.aluResult == '0);
		nextFlags.s = execOp.aluResult[`FORTH_DATA_WIDTH-1];
		// Even number of ones
		nextFlags.p = ~^execOp.aluResult;
		nextFlags.c = execOp.aluCarry;
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			flags <= '0;
		end else if (flagWrite) begin
			flags <= nextFlags;
		end
	end

endmodule

`default_nettype wire

//--- src/branchLogic.sv
`default_nettype none

module branchLogic import forthBranchPkg::*; (
	input  execOpT      execOp,
	input  flagsT       flags,
	output pcOffsetSelT pcOffsetSel,
	output pcBaseSelT   pcBaseSel,
	output logic        taken
);

	logic selectedFlag;
	logic conditionMet;

	always_comb begin
		selectedFlag = flags.z;
		case (execOp.ccSelect)
			CC_Z: selectedFlag = flags.z;
			CC_S: selectedFlag = flags.s;
			CC_P: selectedFlag = flags.p;
			CC_C: selectedFlag = flags.c;
			default: selectedFlag = flags.z;
		endcase
	end

	// Unconditional unless ccApply is set
	assign conditionMet = !execOp.ccApply || (selectedFlag ^ execOp.ccInvert);
	assign taken = execOp.valid && execOp.jmp && conditionMet;

	always_comb begin
		pcOffsetSel = PC_OFFSET_NONE;
		pcBaseSel = PC_BASE_PC;
		if (taken) begin
			pcOffsetSel = PC_OFFSET_D;
			// jr picks own address, otherwise absolute from zero
			if (execOp.jr) begin
				pcBaseSel = PC_BASE_PCA;
			end else begin
				pcBaseSel = PC_BASE_ZERO;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/programCounter.sv
`default_nettype none

`include "forthBranch_config.svh"

module programCounter import forthBranchPkg::*; (
	input  logic                         CLK,
	input  logic                         reset,
	input  execOpT                       execOp,
	input  pcOffsetSelT                  pcOffsetSel,
	input  pcBaseSelT                    pcBaseSel,
	input  logic                         taken,
	output logic [`FORTH_DATA_WIDTH-1:0] pc,
	output logic                         branchTaken
);

	logic [`FORTH_DATA_WIDTH-1:0] offset;
	logic [`FORTH_DATA_WIDTH-1:0] base;
	logic [`FORTH_DATA_WIDTH-1:0] nextPc;

	always_comb begin
		case (pcOffsetSel)
			PC_OFFSET_D: offset = execOp.dValue;
			default: offset = `FORTH_DATA_WIDTH'(`FORTH_PC_STEP);
		endcase
	end

	always_comb begin
		case (pcBaseSel)
			PC_BASE_ZERO: base = '0;
			PC_BASE_PCA: base = execOp.pcA;
			default: base = pc;
		endcase
	end

	// Wraps at the datapath width
	assign nextPc = base + offset;

	always_ff @(posedge CLK) begin
		if (reset) begin
			pc <= `FORTH_RESET_PC;
			branchTaken <= 1'b0;
		end else begin
			branchTaken <= execOp.valid && taken;
			if (execOp.valid) begin
				pc <= nextPc;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/branchUnit.sv
`default_nettype none

`include "forthBranch_config.svh"

module branchUnit import forthBranchPkg::*; (
	input  logic                         CLK,
	input  logic                         reset,
	input  logic                         instrValid,
	input  instrWordT                    instr,
	input  logic [`FORTH_DATA_WIDTH-1:0] dValue,
	input  logic [`FORTH_DATA_WIDTH-1:0] aluResult,
	input  logic                         aluCarry,
	output logic [`FORTH_DATA_WIDTH-1:0] pc,
	output logic                         branchTaken
);

	execOpT      execOp;
	flagsT       flags;
	pcOffsetSelT pcOffsetSel;
	pcBaseSelT   pcBaseSel;
	logic        taken;

	instructionDecoder u_decoder (
		.CLK        (CLK),
		.reset      (reset),
		.instrValid (instrValid),
		.instr      (instr),
		.dValue     (dValue),
		.aluResult  (aluResult),
		.aluCarry   (aluCarry),
		.pc         (pc),
		.execOp     (execOp)
	);

	conditionCodes u_conditionCodes (
		.CLK    (CLK),
		.reset  (reset),
		.execOp (execOp),
		.flags  (flags)
	);

	// Flags seen here are the ones left by the previous instruction
	branchLogic u_branchLogic (
		.execOp      (execOp),
		.flags       (flags),
		.pcOffsetSel (pcOffsetSel),
		.pcBaseSel   (pcBaseSel),
		.taken       (taken)
	);

	programCounter u_programCounter (
		.CLK         (CLK),
		.reset       (reset),
		.execOp      (execOp),
		.pcOffsetSel (pcOffsetSel),
		.pcBaseSel   (pcBaseSel),
		.taken       (taken),
		.pc          (pc),
		.branchTaken (branchTaken)
	);

endmodule

`default_nettype wire

//--- sim/branchUnit_checker.sv
`default_nettype none

`include "forthBranch_config.svh"

module branchUnit_checker (
	input logic                         CLK,
	input logic                         reset,
	input logic                         instrValid,
	input logic [`FORTH_DATA_WIDTH-1:0] pc,
	input logic                         branchTaken
);

	// Read by the testbench at the end of the run
	int assertFailures = 0;

	// Empty execute slot can never retire a jump
	idleNoTaken: assert property (@(posedge CLK) disable iff (reset)
		!instrValid |-> ##2 !branchTaken)
	else begin
		assertFailures++;
		$error("branchTaken was high after an idle cycle");
	end

	// Sequential step when no jump retires
	stepByOne: assert property (@(posedge CLK) disable iff (reset)
		instrValid |-> ##2 (branchTaken || (pc == ($past(pc) + `FORTH_DATA_WIDTH'(1)))))
	else begin
		assertFailures++;
		$error("pc did not step by one after a non-taken instruction");
	end

	idleHoldsPc: assert property (@(posedge CLK) disable iff (reset)
		!instrValid |-> ##2 $stable(pc))
	else begin
		assertFailures++;
		$error("pc changed after an idle cycle");
	end

	resetValues: assert property (@(posedge CLK)
		reset |=> ((pc == `FORTH_RESET_PC) && !branchTaken))
	else begin
		assertFailures++;
		$error("outputs were not at their reset values after reset");
	end

endmodule

bind branchUnit branchUnit_checker u_checker (
	.CLK         (CLK),
	.reset       (reset),
	.instrValid  (instrValid),
	.pc          (pc),
	.branchTaken (branchTaken)
);

`default_nettype wire

//--- sim/branchUnitTb.sv
`default_nettype none

`include "forthBranch_config.svh"

module branchUnitTb import forthBranchPkg::*; ();

	localparam int vectorFields = 7;
	localparam int maxVectors = 64;
	localparam int memWords = vectorFields * maxVectors;
	localparam logic [`FORTH_DATA_WIDTH-1:0] endMarker = 16'hFFFF;

	logic                         CLK;
	logic                         reset;
	logic                         instrValid;
	instrWordT                    instr;
	logic [`FORTH_DATA_WIDTH-1:0] dValue;
	logic [`FORTH_DATA_WIDTH-1:0] aluResult;
	logic                         aluCarry;
	logic [`FORTH_DATA_WIDTH-1:0] pc;
	logic                         branchTaken;

	// Seven words per vector, in file column order
	logic [`FORTH_DATA_WIDTH-1:0] vecMem [0:memWords-1];

	int numVectors = 0;
	int cycleCount = 0;

	branchUnit u_dut (
		.CLK         (CLK),
		.reset       (reset),
		.instrValid  (instrValid),
		.instr       (instr),
		.dValue      (dValue),
		.aluResult   (aluResult),
		.aluCarry    (aluCarry),
		.pc          (pc),
		.branchTaken (branchTaken)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= numVectors + 20) begin
			$display("Timed out: the vector run did not finish within %0d cycles", cycleCount);
			$display("Simulation failed");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	// Stop at the first violation flagged by the bound checker
	always @(negedge CLK) begin
		if (u_dut.u_checker.assertFailures != 0) begin
			$display("Bound checker reported an assertion failure");
			$display("Simulation failed");
			$fatal(1, "assertion failure in the checker");
		end
	end

	task automatic checkValue(input string name, input logic [`FORTH_DATA_WIDTH-1:0] expected,
		input logic [`FORTH_DATA_WIDTH-1:0] actual);
		if (actual !== expected) begin
			$display("FAIL %s expected 0x%h actual 0x%h", name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// Vectors run up to the line whose valid column holds the end marker
	function automatic int countVectors();
		int count;
		count = 0;
		while (count < maxVectors && vecMem[count * vectorFields] !== endMarker) begin
			count++;
		end
		if (count == maxVectors) begin
			count = -1;
		end
		return count;
	endfunction

	task automatic driveVector(input int idx);
		int base;
		base = idx * vectorFields;
		instrValid = vecMem[base][0];
		instr = vecMem[base + 1];
		dValue = vecMem[base + 2];
		aluResult = vecMem[base + 3];
		aluCarry = vecMem[base + 4][0];
	endtask

	task automatic driveIdle();
		instrValid = 1'b0;
		instr = '0;
		dValue = '0;
		aluResult = '0;
		aluCarry = 1'b0;
	endtask

	task automatic checkVector(input int idx);
		int base;
		base = idx * vectorFields;
		checkValue("pc", vecMem[base + 5], pc);
		checkValue("branchTaken", vecMem[base + 6], `FORTH_DATA_WIDTH'(branchTaken));
	endtask

	initial begin
		reset = 1'b1;
		driveIdle();
		$readmemh("sim/branchVectors.txt", vecMem);
		numVectors = countVectors();
		if (numVectors <= 0) begin
			$display("The vector file held no vectors or no end marker");
			$display("Simulation failed");
			$fatal(1, "vector file unusable");
		end

		repeat (2) @(posedge CLK);
		@(negedge CLK);
		checkValue("pc", `FORTH_RESET_PC, pc);
		checkValue("branchTaken", '0, `FORTH_DATA_WIDTH'(branchTaken));
		reset = 1'b0;

		// Results of a line show up two falling edges after it is driven
		for (int n = 0; n < numVectors + 2; n++) begin
			if (n >= 2) begin
				checkVector(n - 2);
			end
			if (n < numVectors) begin
				driveVector(n);
			end else begin
				driveIdle();
			end
			@(negedge CLK);
		end

		if (u_dut.u_checker.assertFailures == 0) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			$display("Bound checker reported %0d assertion failures",
				u_dut.u_checker.assertFailures);
			$display("Simulation failed");
			$fatal(1, "assertion failures in the checker");
		end
	end

endmodule

`default_nettype wire

//--- sim/branchVectors.txt
// valid instr dValue aluResult aluCarry expectedPc expectedTaken
// expected columns are the outputs after that line executes, valid FFFF ends the run
1 1000 0000 0000 0 0101 0
1 0000 0000 0000 0 0102 0
0 0000 0000 0000 0 0102 0
0 0000 0000 0000 0 0102 0
1 1000 1234 5678 1 0103 0
// conditional branches with all flags clear
1 F400 2000 0000 0 0104 0
1 F480 2000 0000 0 0105 0
1 F500 2000 0000 0 0106 0
1 F580 2000 0000 0 0107 0
1 1800 3000 0000 1 0108 0
1 1800 3000 8001 0 0109 0
// unconditional jumps
1 F000 0200 0000 0 0200 1
1 1000 0000 0000 0 0201 0
1 F800 0010 0000 0 0211 1
0 F000 1234 0000 0 0211 0
1 F000 FFF0 0000 0 FFF0 1
1 F800 0020 0000 1 0010 1
1 F000 FFFF 0000 0 FFFF 1
1 1000 0000 0000 0 0000 0
1 F400 0300 0000 0 0001 0
1 F000 0300 0000 0 0300 1
// conditional jumps on Z S P C
1 1800 0000 0000 0 0301 0
1 F400 0400 0000 0 0400 1
1 F600 0500 0000 0 0401 0
1 1800 0000 8000 1 0402 0
1 FC80 0010 0000 0 0412 1
1 F500 0600 0000 0 0413 0
1 F700 0600 0000 0 0600 1
1 F580 0700 0000 0 0700 1
1 F780 0800 0000 0 0701 0
1 1800 0000 0007 0 0702 0
1 F480 0900 0000 0 0703 0
1 F680 0900 0000 0 0900 1
1 F600 0A00 0000 0 0A00 1
// back to back flag write and branches
1 1800 0000 0003 1 0A01 0
1 FD00 0040 0000 0 0A41 1
1 F800 FFFF 0000 0 0A40 1
1 F800 0002 0000 0 0A42 1
1 1000 0000 0000 0 0A43 0
0 0000 0000 0000 0 0A43 0
1 FF80 0100 0000 0 0A44 0
FFFF 0000 0000 0000 0 0000 0

//--- filelist.f
+incdir+src
src/forthBranchPkg.sv
src/instructionDecoder.sv
src/conditionCodes.sv
src/branchLogic.sv
src/programCounter.sv
src/branchUnit.sv
sim/branchUnit_checker.sv
sim/branchUnitTb.sv

//--- Bender.yml
package:
  name: forth_branch

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/forthBranchPkg.sv
      - src/instructionDecoder.sv
      - src/conditionCodes.sv
      - src/branchLogic.sv
      - src/programCounter.sv
      - src/branchUnit.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/branchUnit_checker.sv
      - sim/branchUnitTb.sv
